// ==== logic/core_pkg.sv ====
package core_pkg;

    localparam int xlen   = 32;
    localparam int reg_aw = 5;

    localparam logic [xlen-1:0] start_addr = 32'h0000_0000;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst   = 32'h0000_0013;

    typedef enum logic [3:0] {
        op_add, op_sub, op_and, op_or, op_xor, op_slt,
        op_addi, op_lui, op_lw, op_sw, op_sb,
        op_beq, op_bne, op_jal, op_ill
    } op_e;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   pc;
        op_e               op;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] rs1;
        logic [reg_aw-1:0] rs2;
        logic [xlen-1:0]   imm;
    } dec_t;

    typedef struct packed {
        logic              valid;
        logic [xlen-1:0]   pc;
        logic              reg_w_en;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   reg_w_data;
        logic              mem_r_en;
        logic              mem_w_en;
        logic [xlen-1:0]   mem_addr;
        logic [3:0]        mem_w_strb;
        logic [xlen-1:0]   mem_w_data;
        logic              jmp_do;
        logic [xlen-1:0]   jmp_pc;
    } exe_t;

    // register write leaving mread
    typedef struct packed {
        logic              en;
        logic [reg_aw-1:0] rd;
        logic [xlen-1:0]   data;
    } wb_t;

endpackage

// ==== logic/fetch.sv ====
`timescale 1ns/1ps

module fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      mem_wait,
    input  logic [core_pkg::xlen-1:0] flush_pc,
    input  logic [core_pkg::xlen-1:0] inst_roaddr,
    input  logic                      inst_rvalid,
    input  logic [core_pkg::xlen-1:0] inst_rdata,
    output logic                      inst_rden,
    output logic [core_pkg::xlen-1:0] inst_riaddr,
    output core_pkg::fetch_t          fetch_out
);
    import core_pkg::*;

    logic [xlen-1:0] req_pc;
    logic [xlen-1:0] exp_pc;
    logic            run;
    logic            hit;

    assign inst_rden   = run && !stall && !flush && !mem_wait;
    assign inst_riaddr = req_pc;
    // only the response for the next expected pc is taken
    assign hit = inst_rvalid && (inst_roaddr == exp_pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            run       <= 1'b0;
            req_pc    <= start_addr;
            exp_pc    <= start_addr;
            fetch_out <= '{valid: 1'b0, pc: start_addr, inst: nop_inst};
        end else begin
            run <= 1'b1;
            if (mem_wait || (stall && !flush)) begin
                // response cannot be accepted now, ask for it again
                if (hit) begin
                    req_pc <= exp_pc;
                end
            end else if (flush) begin
                req_pc          <= flush_pc;
                exp_pc          <= flush_pc;
                fetch_out.valid <= 1'b0;
                fetch_out.inst  <= nop_inst;
            end else begin
                if (inst_rden) begin
                    req_pc <= req_pc + xlen'(4);
                end
                if (hit) begin
                    fetch_out <= '{valid: 1'b1, pc: exp_pc, inst: inst_rdata};
                    exp_pc    <= exp_pc + xlen'(4);
                end else begin
                    fetch_out.valid <= 1'b0;
                    fetch_out.inst  <= nop_inst;
                end
            end
        end
    end

endmodule

// ==== logic/decode.sv ====
`timescale 1ns/1ps

module decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             stall,
    input  logic             mem_wait,
    input  core_pkg::fetch_t fetch_in,
    output core_pkg::dec_t   dec_out
);
    import core_pkg::*;

    logic [xlen-1:0] inst;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [9:0]      fn;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    dec_t            nxt;

    assign inst  = fetch_in.inst;
    assign opc   = inst[6:0];
    assign f3    = inst[14:12];
    // funct7 and funct3 together
    assign fn    = {inst[31:25], f3};
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        nxt       = '0;
        nxt.valid = fetch_in.valid;
        nxt.pc    = fetch_in.pc;
        nxt.rd    = inst[11:7];
        nxt.rs1   = inst[19:15];
        nxt.op    = op_ill;
        case (opc)
            7'b0110011: begin
                nxt.rs2 = inst[24:20];
                case (fn)
                    10'b0000000_000: nxt.op = op_add;
                    10'b0100000_000: nxt.op = op_sub;
                    10'b0000000_111: nxt.op = op_and;
                    10'b0000000_110: nxt.op = op_or;
                    10'b0000000_100: nxt.op = op_xor;
                    10'b0000000_010: nxt.op = op_slt;
                    default: ;
                endcase
            end
            7'b0010011: begin
                nxt.imm = imm_i;
                nxt.op  = (f3 == 3'b000) ? op_addi : op_ill;
            end
            7'b0110111: begin
                nxt.rs1 = '0;
                nxt.imm = imm_u;
                nxt.op  = op_lui;
            end
            7'b0000011: begin
                nxt.imm = imm_i;
                nxt.op  = (f3 == 3'b010) ? op_lw : op_ill;
            end
            7'b0100011: begin
                nxt.rd  = '0;
                nxt.rs2 = inst[24:20];
                nxt.imm = imm_s;
                if (f3 == 3'b010) begin
                    nxt.op = op_sw;
                end else if (f3 == 3'b000) begin
                    nxt.op = op_sb;
                end
            end
            7'b1100011: begin
                nxt.rd  = '0;
                nxt.rs2 = inst[24:20];
                nxt.imm = imm_b;
                if (f3 == 3'b000) begin
                    nxt.op = op_beq;
                end else if (f3 == 3'b001) begin
                    nxt.op = op_bne;
                end
            end
            7'b1101111: begin
                nxt.rs1 = '0;
                nxt.imm = imm_j;
                nxt.op  = op_jal;
            end
            default: ;
        endcase
        // illegal op passes as a bubble, no register use
        if (nxt.op == op_ill) begin
            nxt.rd  = '0;
            nxt.rs1 = '0;
            nxt.rs2 = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_out <= '0;
        end else if (!mem_wait) begin
            if (flush) begin
                dec_out <= '0;
            end else if (!stall) begin
                dec_out <= nxt;
            end
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [core_pkg::reg_aw-1:0] rs1_addr,
    input  logic [core_pkg::reg_aw-1:0] rs2_addr,
    input  core_pkg::exe_t              fwd_exec,
    input  core_pkg::wb_t               wb,
    output logic [core_pkg::xlen-1:0]   rs1_data,
    output logic [core_pkg::xlen-1:0]   rs2_data,
    output logic                        rs1_valid,
    output logic                        rs2_valid
);
    import core_pkg::*;

    logic [xlen-1:0] regs [2**reg_aw];

    // exec result first, then mread write, then the array
    function automatic logic [xlen-1:0] fwd_data(input logic [reg_aw-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (fwd_exec.valid && fwd_exec.reg_w_en && fwd_exec.rd == addr) begin
            return fwd_exec.reg_w_data;
        end else if (wb.en && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    // load data not back yet
    function automatic logic fwd_ok(input logic [reg_aw-1:0] addr);
        return (addr == '0) || !(fwd_exec.valid && fwd_exec.mem_r_en && fwd_exec.rd == addr);
    endfunction

    always_comb begin
        rs1_data  = fwd_data(rs1_addr);
        rs2_data  = fwd_data(rs2_addr);
        rs1_valid = fwd_ok(rs1_addr);
        rs2_valid = fwd_ok(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**reg_aw; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

// ==== logic/exec.sv ====
`timescale 1ns/1ps

module exec (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      stall,
    input  logic                      mem_wait,
    input  core_pkg::dec_t            dec_in,
    input  logic [core_pkg::xlen-1:0] rs1_data,
    input  logic [core_pkg::xlen-1:0] rs2_data,
    output core_pkg::exe_t            exe_out
);
    import core_pkg::*;

    logic [xlen-1:0] ls_addr;
    exe_t            nxt;

    assign ls_addr = rs1_data + dec_in.imm;

    always_comb begin
        nxt          = '0;
        nxt.valid    = dec_in.valid && dec_in.op != op_ill;
        nxt.pc       = dec_in.pc;
        nxt.rd       = dec_in.rd;
        nxt.mem_addr = ls_addr;
        nxt.jmp_pc   = dec_in.pc + dec_in.imm;
        case (dec_in.op)
            op_add:  nxt.reg_w_data = rs1_data + rs2_data;
            op_sub:  nxt.reg_w_data = rs1_data - rs2_data;
            op_and:  nxt.reg_w_data = rs1_data & rs2_data;
            op_or:   nxt.reg_w_data = rs1_data | rs2_data;
            op_xor:  nxt.reg_w_data = rs1_data ^ rs2_data;
            op_slt:  nxt.reg_w_data = ($signed(rs1_data) < $signed(rs2_data)) ? xlen'(1) : '0;
            op_addi: nxt.reg_w_data = rs1_data + dec_in.imm;
            op_lui:  nxt.reg_w_data = dec_in.imm;
            // link address
            op_jal:  nxt.reg_w_data = dec_in.pc + xlen'(4);
            op_sw: begin
                nxt.mem_w_strb = 4'b1111;
                nxt.mem_w_data = rs2_data;
            end
            op_sb: begin
                // byte moved to its lane
                nxt.mem_w_strb = 4'b0001 << ls_addr[1:0];
                nxt.mem_w_data = xlen'(rs2_data[7:0]) << {ls_addr[1:0], 3'b000};
            end
            op_beq:  nxt.jmp_do = (rs1_data == rs2_data);
            op_bne:  nxt.jmp_do = (rs1_data != rs2_data);
            default: ;
        endcase
        nxt.reg_w_en = dec_in.op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
                                         op_addi, op_lui, op_lw, op_jal};
        nxt.mem_r_en = (dec_in.op == op_lw);
        nxt.mem_w_en = dec_in.op inside {op_sw, op_sb};
        if (dec_in.op == op_jal) begin
            nxt.jmp_do = 1'b1;
        end
        if (!nxt.valid) begin
            nxt = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe_out <= '0;
        end else if (!mem_wait) begin
            // bubble on stall, decode keeps the instruction
            if (flush || stall) begin
                exe_out <= '0;
            end else begin
                exe_out <= nxt;
            end
        end
    end

endmodule

// ==== logic/mread.sv ====
`timescale 1ns/1ps

module mread (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      mem_wait,
    input  core_pkg::exe_t            exe_in,
    input  logic [core_pkg::xlen-1:0] data_roaddr,
    input  logic                      data_rvalid,
    input  logic [core_pkg::xlen-1:0] data_rdata,
    output logic                      data_rden,
    output logic [core_pkg::xlen-1:0] data_riaddr,
    output logic                      data_wren,
    output logic [3:0]                data_wstrb,
    output logic [core_pkg::xlen-1:0] data_waddr,
    output logic [core_pkg::xlen-1:0] data_wdata,
    output core_pkg::wb_t             wb,
    output logic                      load_busy,
    output logic                      jmp_do,
    output logic [core_pkg::xlen-1:0] jmp_pc
);
    import core_pkg::*;

    logic              take;
    logic              hit;
    logic              got;
    logic              pending;
    logic              issued;
    logic              ld_got;
    logic [reg_aw-1:0] ld_rd;
    logic [xlen-1:0]   ld_addr;
    logic [xlen-1:0]   ld_data;
    logic              st_en;

    // wrong-path instruction behind a jump is dropped
    assign take      = exe_in.valid && !flush;
    assign load_busy = pending || (take && exe_in.mem_r_en);

    assign data_rden   = pending && !issued && !mem_wait;
    assign data_riaddr = ld_addr;
    assign hit         = data_rvalid && issued && (data_roaddr == ld_addr);
    assign got         = ld_got || hit;
    assign data_wren   = st_en && !mem_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            issued  <= 1'b0;
            ld_got  <= 1'b0;
            st_en   <= 1'b0;
            jmp_do  <= 1'b0;
            wb.en   <= 1'b0;
        end else begin
            if (data_rden) begin
                issued <= 1'b1;
            end
            // return may come while frozen, keep it
            if (hit) begin
                ld_got  <= 1'b1;
                ld_data <= data_rdata;
            end
            if (!mem_wait) begin
                wb.en  <= 1'b0;
                st_en  <= 1'b0;
                jmp_do <= 1'b0;
                if (pending) begin
                    if (got) begin
                        wb.en   <= 1'b1;
                        wb.rd   <= ld_rd;
                        wb.data <= ld_got ? ld_data : data_rdata;
                        pending <= 1'b0;
                        issued  <= 1'b0;
                        ld_got  <= 1'b0;
                    end
                end else if (take) begin
                    wb.en      <= exe_in.reg_w_en && !exe_in.mem_r_en;
                    wb.rd      <= exe_in.rd;
                    wb.data    <= exe_in.reg_w_data;
                    st_en      <= exe_in.mem_w_en;
                    data_wstrb <= exe_in.mem_w_strb;
                    data_waddr <= exe_in.mem_addr;
                    data_wdata <= exe_in.mem_w_data;
                    jmp_do     <= exe_in.jmp_do;
                    jmp_pc     <= exe_in.jmp_pc;
                    pending    <= exe_in.mem_r_en;
                    ld_rd      <= exe_in.rd;
                    ld_addr    <= exe_in.mem_addr;
                end
            end
        end
    end

endmodule

// ==== logic/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_wait,

    // instruction port
    output logic                      inst_rden,
    output logic [core_pkg::xlen-1:0] inst_riaddr,
    input  logic [core_pkg::xlen-1:0] inst_roaddr,
    input  logic                      inst_rvalid,
    input  logic [core_pkg::xlen-1:0] inst_rdata,

    // data port
    output logic                      data_rden,
    output logic [core_pkg::xlen-1:0] data_riaddr,
    input  logic [core_pkg::xlen-1:0] data_roaddr,
    input  logic                      data_rvalid,
    input  logic [core_pkg::xlen-1:0] data_rdata,
    output logic                      data_wren,
    output logic [3:0]                data_wstrb,
    output logic [core_pkg::xlen-1:0] data_waddr,
    output logic [core_pkg::xlen-1:0] data_wdata
);
    import core_pkg::*;

    logic            flush;
    logic [xlen-1:0] flush_pc;
    logic            stall;
    fetch_t          fetch_out;
    dec_t            dec_out;
    exe_t            exe_out;
    wb_t             wb;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rs1_valid;
    logic            rs2_valid;
    logic            load_busy;
    logic            jmp_do;
    logic [xlen-1:0] jmp_pc;

    // taken jump leaving mread redirects the front end
    assign flush    = jmp_do;
    assign flush_pc = jmp_pc;
    assign stall    = !rs1_valid || !rs2_valid || load_busy;

    fetch fetch (.*);

    decode decode (
        .*,
        .fetch_in (fetch_out)
    );

    reg_file reg_file_0 (
        .*,
        .rs1_addr (dec_out.rs1),
        .rs2_addr (dec_out.rs2),
        .fwd_exec (exe_out)
    );

    exec exec (
        .*,
        .dec_in (dec_out)
    );

    mread mread (
        .*,
        .exe_in (exe_out)
    );

endmodule

// ==== dv/core_props.sv ====
`timescale 1ns/1ps

module core_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      mem_wait,
    input logic                      inst_rden,
    input logic [core_pkg::xlen-1:0] inst_riaddr,
    input logic                      data_wren,
    input logic [3:0]                data_wstrb
);
    // first edge still sees the unreset core
    logic armed = 1'b0;
    int   fails = 0;

    always @(posedge clk) begin
        armed <= 1'b1;
    end

    quiet_when_held: assert property (@(posedge clk)
        armed && (rst || mem_wait) |-> !data_wren && !inst_rden)
        else begin
            $error("read or write strobe high during reset or mem_wait");
            fails++;
        end

    strobe_present: assert property (@(posedge clk)
        armed && data_wren |-> data_wstrb != 4'b0000)
        else begin
            $error("data write with empty strobe");
            fails++;
        end

    fetch_aligned: assert property (@(posedge clk)
        armed |-> inst_riaddr[1:0] == 2'b00)
        else begin
            $error("instruction address not word aligned");
            fails++;
        end

endmodule

bind core_top core_props u_props (.*);

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;
    import core_pkg::*;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rst;
    logic        mem_wait;
    logic        inst_rden;
    logic [31:0] inst_riaddr;
    logic [31:0] inst_roaddr;
    logic        inst_rvalid;
    logic [31:0] inst_rdata;
    logic        data_rden;
    logic [31:0] data_riaddr;
    logic [31:0] data_roaddr;
    logic        data_rvalid;
    logic [31:0] data_rdata;
    logic        data_wren;
    logic [3:0]  data_wstrb;
    logic [31:0] data_waddr;
    logic [31:0] data_wdata;

    logic [31:0] imem [64];
    store_t      exp_q [$];
    int          npass;
    int          nfail;
    int          sidx;

    core_top u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input int rd,
                                           input int rs1, input logic [31:0] imm);
        return {imm[11:0], 5'(rs1), (opc == 7'b0000011) ? 3'b010 : 3'b000, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input int rs2,
                                           input int rs1, input logic [31:0] imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                           input int rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    // data memory content from the full address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ addr ^ 32'h5a5a_c3c3;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[FAIL] t=%0d ns %s: got %h expected %h", $time, name, got, want);
        nfail++;
    endtask

    task automatic load_program();
        foreach (imem[i]) begin
            imem[i] = nop_inst;
        end
        imem[0]  = u_type(1, 20'h12345);
        imem[1]  = i_type(7'b0010011, 1, 1, 32'h678);
        imem[2]  = i_type(7'b0010011, 2, 0, 32'h0f0);
        imem[3]  = r_type(7'b0000000, 3'b000, 3, 1, 2);
        imem[4]  = r_type(7'b0100000, 3'b000, 4, 3, 2);
        imem[5]  = r_type(7'b0000000, 3'b100, 5, 4, 3);
        imem[6]  = r_type(7'b0000000, 3'b111, 6, 3, 2);
        imem[7]  = r_type(7'b0000000, 3'b110, 7, 6, 5);
        imem[8]  = r_type(7'b0000000, 3'b010, 8, 2, 1);
        imem[9]  = i_type(7'b0010011, 10, 0, 32'h300);
        imem[10] = s_type(3'b010, 3, 10, 0);
        imem[11] = s_type(3'b010, 4, 10, 4);
        imem[12] = s_type(3'b010, 5, 10, 8);
        imem[13] = s_type(3'b010, 7, 10, 12);
        imem[14] = s_type(3'b010, 8, 10, 16);
        // load then dependent add
        imem[15] = i_type(7'b0000011, 11, 0, 32'h200);
        imem[16] = r_type(7'b0000000, 3'b000, 12, 11, 1);
        imem[17] = s_type(3'b010, 12, 10, 20);
        imem[18] = b_type(3'b000, 4, 1, 8);
        imem[19] = s_type(3'b010, 1, 10, 24);
        imem[20] = b_type(3'b001, 2, 0, 8);
        imem[21] = s_type(3'b010, 2, 10, 28);
        // not taken
        imem[22] = b_type(3'b000, 2, 0, 8);
        imem[23] = s_type(3'b010, 2, 10, 32);
        imem[24] = j_type(13, 8);
        imem[25] = s_type(3'b010, 0, 10, 36);
        imem[26] = s_type(3'b010, 13, 10, 40);
        imem[27] = s_type(3'b000, 1, 10, 45);
        imem[28] = s_type(3'b000, 3, 10, 46);
        // spin here
        imem[29] = j_type(0, 0);
    endtask

    task automatic build_expected();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [31:0] r7;
        logic [31:0] r8;
        logic [31:0] r12;
        r1  = 32'h1234_5000 + 32'h678;
        r2  = 32'h0f0;
        r3  = r1 + r2;
        r4  = r3 - r2;
        r5  = r4 ^ r3;
        r7  = (r3 & r2) | r5;
        // 0xf0 is below 0x12345678 as signed values
        r8  = 32'd1;
        r12 = fill_word(32'h200) + r1;
        exp_q.push_back(store_t'{32'h300, 4'b1111, r3});
        exp_q.push_back(store_t'{32'h304, 4'b1111, r4});
        exp_q.push_back(store_t'{32'h308, 4'b1111, r5});
        exp_q.push_back(store_t'{32'h30c, 4'b1111, r7});
        exp_q.push_back(store_t'{32'h310, 4'b1111, r8});
        exp_q.push_back(store_t'{32'h314, 4'b1111, r12});
        exp_q.push_back(store_t'{32'h320, 4'b1111, r2});
        // link of the jal at 0x60
        exp_q.push_back(store_t'{32'h328, 4'b1111, 32'h64});
        exp_q.push_back(store_t'{32'h32d, 4'b0010, {16'h0, r1[7:0], 8'h0}});
        exp_q.push_back(store_t'{32'h32e, 4'b0100, {8'h0, r3[7:0], 16'h0}});
    endtask

    // one-cycle memory with address echo
    always @(posedge clk) begin
        inst_rvalid <= !rst && inst_rden;
        inst_roaddr <= inst_riaddr;
        inst_rdata  <= imem[inst_riaddr[7:2]];
        data_rvalid <= !rst && data_rden;
        data_roaddr <= data_riaddr;
        data_rdata  <= fill_word(data_riaddr);
        mem_wait    <= !rst && ($urandom % 4 == 0);
    end

    // the only load in the program reads 0x200
    always @(posedge clk) begin
        if (!rst && data_rden) begin
            assert (data_riaddr == 32'h200) begin
                npass++;
                $display("load request: address %h", data_riaddr);
            end else begin
                report_mismatch("data_riaddr", data_riaddr, 32'h200);
            end
        end
    end

    always @(posedge clk) begin
        store_t got;
        store_t want;
        if (!rst && data_wren) begin
            got = store_t'{data_waddr, data_wstrb, data_wdata};
            if (exp_q.size() == 0) begin
                $display("unexpected store at t=%0d ns to address %h", $time, data_waddr);
                nfail++;
            end else begin
                want = exp_q.pop_front();
                assert (got.addr == want.addr)
                    else report_mismatch("data_waddr", got.addr, want.addr);
                assert (got.strb == want.strb)
                    else report_mismatch("data_wstrb", 32'(got.strb), 32'(want.strb));
                assert (got.data == want.data)
                    else report_mismatch("data_wdata", got.data, want.data);
                if (got == want) begin
                    npass++;
                    $display("store %0d ok: %h strobe %b data %h", sidx, got.addr, got.strb,
                             got.data);
                end
                sidx++;
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'hb434_ab3b));
        clk         = 1'b0;
        rst         = 1'b1;
        mem_wait    = 1'b0;
        inst_rvalid = 1'b0;
        inst_roaddr = '0;
        inst_rdata  = nop_inst;
        data_rvalid = 1'b0;
        data_roaddr = '0;
        data_rdata  = '0;
        npass       = 0;
        nfail       = 0;
        sidx        = 0;
        load_program();
        build_expected();

        repeat (5) @(posedge clk);
        assert (!inst_rden && !data_wren) begin
            npass++;
            $display("reset: read and write strobes low");
        end else begin
            $display("read or write strobe active while in reset");
            nfail++;
        end
        rst <= 1'b0;

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!inst_rden && cycles < 50);
        if (!inst_rden) begin
            $display("timeout waiting for the first instruction request");
            nfail++;
        end else begin
            assert (inst_riaddr == start_addr) begin
                npass++;
                $display("first fetch: address %h", inst_riaddr);
            end else begin
                report_mismatch("inst_riaddr", inst_riaddr, start_addr);
            end
        end

        cycles = 0;
        while (exp_q.size() != 0 && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout with %0d stores still expected", exp_q.size());
            nfail++;
        end
        // catch stores from skipped instructions
        repeat (40) @(posedge clk);

        $display("checks: %0d passed, %0d failed, %0d assertion failures", npass, nfail,
                 u_dut.u_props.fails);
        if (nfail == 0 && u_dut.u_props.fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
logic/core_pkg.sv
logic/fetch.sv
logic/decode.sv
logic/reg_file.sv
logic/exec.sv
logic/mread.sv
logic/core_top.sv
dv/core_props.sv
dv/core_tb.sv
